// File: hdl/systolic_macros.svh
// array and credit sizes for the systolic engine, included by the package and every RTL module
`ifndef SYSTOLIC_MACROS_SVH
`define SYSTOLIC_MACROS_SVH

// rows, columns and vector length
`define SA_DIM 4
// index field width for row, column and lane
`define SA_IDX_W 2

`define SA_DATA_W 16
`define SA_PSUM_W 32

// beat queue depth, equal to the sender's starting credits
`define SA_IN_CREDITS 4
`define SA_OUT_CREDITS 4

`endif

// File: hdl/systolic_pkg.sv
// beat, payload union and result vector types, imported by the engine RTL and its testbench
`include "systolic_macros.svh"

package systolic_pkg;

    typedef logic signed [`SA_DATA_W-1:0] data_t;
    typedef logic signed [`SA_PSUM_W-1:0] psum_t;

    typedef enum logic {
        BEAT_WGT = 1'b0,
        BEAT_ACT = 1'b1
    } beat_kind_e;

    // writes the stationary weight of PE (row, col)
    typedef struct packed {
        logic [`SA_IDX_W-1:0] row;
        logic [`SA_IDX_W-1:0] col;
        data_t                value;
    } wgt_beat_t;

    // one element of an input vector
    typedef struct packed {
        logic [`SA_IDX_W-1:0] rsvd;
        logic [`SA_IDX_W-1:0] lane;
        data_t                value;
    } act_beat_t;

    // same payload word, decoded by the beat kind
    typedef union packed {
        wgt_beat_t wgt;
        act_beat_t act;
    } slice_payload_u;

    typedef struct packed {
        beat_kind_e     kind;
        slice_payload_u payload;
    } slice_beat_t;

    typedef data_t [`SA_DIM-1:0] act_vec_t;
    // element j is column j
    typedef psum_t [`SA_DIM-1:0] result_vec_t;

endpackage

// File: hdl/beat_queue.sv
// input beat FIFO in front of the controller sized by the sender's credit count
`timescale 1ns/1ps
`include "systolic_macros.svh"

module beat_queue import systolic_pkg::*; (
    input  logic        s_clk,
    input  logic        s_rst,
    input  logic        push,
    input  slice_beat_t push_beat,
    input  logic        pop,
    output slice_beat_t head_beat,
    output logic        not_empty
);

    localparam int DEPTH = `SA_IN_CREDITS;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    slice_beat_t      mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    always_ff @(posedge s_clk) begin
        if (push) begin
            mem[wr_ptr] <= push_beat;
        end
    end

    // the sender never holds more credits than entries
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    assign head_beat = mem[rd_ptr];
    assign not_empty = (count != '0);

endmodule

// File: hdl/systolic_pe.sv
// multiply-accumulate cell of the array, holds one weight and passes data right and down
`timescale 1ns/1ps
`include "systolic_macros.svh"

module systolic_pe (
    input  logic                         s_clk,
    input  logic                         s_rst,
    input  logic                         w_we,
    input  logic signed [`SA_DATA_W-1:0] w_value,
    input  logic                         a_valid_in,
    input  logic signed [`SA_DATA_W-1:0] a_in,
    input  logic signed [`SA_PSUM_W-1:0] psum_in,
    output logic                         a_valid_out,
    output logic signed [`SA_DATA_W-1:0] a_out,
    output logic signed [`SA_PSUM_W-1:0] psum_out
);

    logic signed [`SA_DATA_W-1:0] weight;

    // unloaded cells contribute zero
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            weight      <= '0;
            a_valid_out <= 1'b0;
        end else begin
            if (w_we) begin
                weight <= w_value;
            end
            a_valid_out <= a_valid_in;
        end
    end

    // product widens to the psum width, sum wraps at 32 bits
    always_ff @(posedge s_clk) begin
        a_out    <= a_in;
        psum_out <= a_valid_in ? psum_in + a_in * weight : psum_in;
    end

endmodule

// File: hdl/act_skew_stage.sv
// collects one activation vector by lane and launches it into the rows as a diagonal wavefront
`timescale 1ns/1ps
`include "systolic_macros.svh"

module act_skew_stage import systolic_pkg::*; (
    input  logic                s_clk,
    input  logic                s_rst,
    input  logic                act_we,
    input  act_beat_t           act_beat,
    input  logic                issue,
    output logic                vec_full,
    output logic [`SA_DIM-1:0]  row_valid,
    output act_vec_t            row_data
);

    localparam logic [`SA_IDX_W-1:0] LAST_LANE = `SA_IDX_W'(`SA_DIM - 1);

    act_vec_t           staging;
    // stage k holds the vector k cycles after launch
    act_vec_t           stg_data [`SA_DIM];
    logic [`SA_DIM-1:0] stg_valid;

    always_ff @(posedge s_clk) begin
        if (act_we) begin
            staging[act_beat.lane] <= act_beat.value;
        end
    end

    // lane 3 closes the vector; a new lane 0 may land on the issue cycle
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            vec_full <= 1'b0;
        end else if (act_we && act_beat.lane == LAST_LANE) begin
            vec_full <= 1'b1;
        end else if (issue) begin
            vec_full <= 1'b0;
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            stg_valid <= '0;
        end else begin
            stg_valid <= {stg_valid[`SA_DIM-2:0], issue};
        end
    end

    always_ff @(posedge s_clk) begin
        if (issue) begin
            stg_data[0] <= staging;
        end
        for (int k = 1; k < `SA_DIM; k++) begin
            stg_data[k] <= stg_data[k-1];
        end
    end

    // row i taps stage i, which staggers lane i by i cycles
    always_comb begin
        row_valid = stg_valid;
        for (int i = 0; i < `SA_DIM; i++) begin
            row_data[i] = stg_data[i][i];
        end
    end

endmodule

// File: hdl/systolic_ctrl.sv
// beat router and credit keeper that feeds weights to the grid and issues vectors into the array
`timescale 1ns/1ps
`include "systolic_macros.svh"

module systolic_ctrl import systolic_pkg::*; (
    input  logic                          s_clk,
    input  logic                          s_rst,
    input  logic                          not_empty,
    input  slice_beat_t                   head_beat,
    output logic                          pop,
    output logic                          in_credit,
    output logic [`SA_DIM*`SA_DIM-1:0]    w_we,
    output data_t                         w_value,
    output logic                          act_we,
    output act_beat_t                     act_beat,
    input  logic                          vec_full,
    output logic                          issue,
    input  logic                          done,
    input  logic                          out_credit
);

    localparam int CNT_W = $clog2(`SA_OUT_CREDITS + 1);

    typedef enum logic [1:0] {
        IDLE,
        ROUTE,
        WAIT_DRAIN
    } state_e;

    state_e           state;
    state_e           state_nxt;
    logic [CNT_W-1:0] out_cred;
    logic [CNT_W-1:0] in_flight;
    logic             is_wgt;
    logic             wgt_ok;
    logic             wgt_fire;
    logic             act_fire;

    assign is_wgt = (head_beat.kind == BEAT_WGT);
    // a staged vector came first, so it must leave with the old weights
    assign wgt_ok = (in_flight == '0) && !vec_full;

    assign wgt_fire = (state == ROUTE || state == WAIT_DRAIN) && not_empty && is_wgt && wgt_ok;
    // output credit reserved here, so the array never has to stall
    assign issue    = vec_full && (out_cred != '0);
    assign act_fire = (state == ROUTE) && not_empty && !is_wgt && (!vec_full || issue);
    assign pop      = wgt_fire || act_fire;

    assign act_we   = act_fire;
    assign act_beat = head_beat.payload.act;
    assign w_value  = head_beat.payload.wgt.value;

    always_comb begin
        w_we = '0;
        if (wgt_fire) begin
            w_we[int'(head_beat.payload.wgt.row) * `SA_DIM + int'(head_beat.payload.wgt.col)] = 1'b1;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:       if (not_empty) state_nxt = ROUTE;
            ROUTE: begin
                if (!not_empty) begin
                    state_nxt = IDLE;
                end else if (is_wgt && !wgt_ok) begin
                    state_nxt = WAIT_DRAIN;
                end
            end
            WAIT_DRAIN: if (wgt_ok) state_nxt = ROUTE;
            default:    state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            state     <= IDLE;
            in_credit <= 1'b0;
            out_cred  <= CNT_W'(`SA_OUT_CREDITS);
            in_flight <= '0;
        end else begin
            state     <= state_nxt;
            in_credit <= pop;
            case ({issue, out_credit})
                2'b10:   out_cred <= out_cred - 1'b1;
                2'b01:   out_cred <= out_cred + 1'b1;
                default: ;
            endcase
            case ({issue, done})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

// File: hdl/result_drain.sv
// realigns the bottom-row column outputs into one registered result vector
`timescale 1ns/1ps
`include "systolic_macros.svh"

module result_drain import systolic_pkg::*; (
    input  logic               s_clk,
    input  logic               s_rst,
    input  logic [`SA_DIM-1:0] col_valid,
    input  result_vec_t        col_psum,
    output logic               out_valid,
    output result_vec_t        out_vec,
    output logic               done
);

    localparam int LAST = `SA_DIM - 1;

    // entry k is delayed k+1 cycles
    result_vec_t        psum_pipe  [LAST];
    logic [`SA_DIM-1:0] valid_pipe [LAST];
    psum_t              aligned    [`SA_DIM];
    wire  [`SA_DIM-1:0] aligned_v;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            for (int k = 0; k < LAST; k++) begin
                valid_pipe[k] <= '0;
            end
            out_valid <= 1'b0;
        end else begin
            valid_pipe[0] <= col_valid;
            for (int k = 1; k < LAST; k++) begin
                valid_pipe[k] <= valid_pipe[k-1];
            end
            out_valid <= &aligned_v;
        end
    end

    always_ff @(posedge s_clk) begin
        psum_pipe[0] <= col_psum;
        for (int k = 1; k < LAST; k++) begin
            psum_pipe[k] <= psum_pipe[k-1];
        end
        if (&aligned_v) begin
            for (int j = 0; j < `SA_DIM; j++) begin
                out_vec[j] <= aligned[j];
            end
        end
    end

    // column j is LAST-j cycles early
    for (genvar j = 0; j < `SA_DIM; j++) begin : g_col
        if (j == LAST) begin : g_direct
            assign aligned[j]   = col_psum[j];
            assign aligned_v[j] = col_valid[j];
        end else begin : g_delayed
            assign aligned[j]   = psum_pipe[LAST-1-j][j];
            assign aligned_v[j] = valid_pipe[LAST-1-j][j];
        end
    end

    assign done = out_valid;

endmodule

// File: hdl/systolic_top.sv
// top of the 4x4 weight-stationary engine with credit-based input and result ports
`timescale 1ns/1ps
`include "systolic_macros.svh"

module systolic_top import systolic_pkg::*; (
    input  logic        s_clk,
    input  logic        s_rst,
    input  logic        in_valid,
    input  slice_beat_t in_beat,
    output logic        in_credit,
    output logic        out_valid,
    output result_vec_t out_vec,
    input  logic        out_credit
);

    slice_beat_t                   head_beat;
    logic                          not_empty;
    logic                          pop;
    logic [`SA_DIM*`SA_DIM-1:0]    w_we;
    data_t                         w_value;
    logic                          act_we;
    act_beat_t                     act_beat;
    logic                          vec_full;
    logic                          issue;
    logic                          done;
    logic [`SA_DIM-1:0]            row_valid;
    act_vec_t                      row_data;
    logic [`SA_DIM-1:0]            col_valid;
    result_vec_t                   col_psum;

    // activations move right, psums move down
    logic                          act_v  [`SA_DIM][`SA_DIM+1];
    data_t                         act_d  [`SA_DIM][`SA_DIM+1];
    psum_t                         psum_w [`SA_DIM+1][`SA_DIM];

    beat_queue i_queue (
        .s_clk, .s_rst, .push(in_valid), .push_beat(in_beat), .pop, .head_beat, .not_empty
    );

    systolic_ctrl i_ctrl (
        .s_clk, .s_rst, .not_empty, .head_beat, .pop, .in_credit, .w_we, .w_value,
        .act_we, .act_beat, .vec_full, .issue, .done, .out_credit
    );

    act_skew_stage i_skew (
        .s_clk, .s_rst, .act_we, .act_beat, .issue, .vec_full, .row_valid, .row_data
    );

    for (genvar i = 0; i < `SA_DIM; i++) begin : g_row
        assign act_v[i][0] = row_valid[i];
        assign act_d[i][0] = row_data[i];
        assign psum_w[0][i] = '0;
        for (genvar j = 0; j < `SA_DIM; j++) begin : g_pe
            systolic_pe i_pe (
                .s_clk, .s_rst,
                .w_we(w_we[i*`SA_DIM+j]), .w_value,
                .a_valid_in(act_v[i][j]), .a_in(act_d[i][j]), .psum_in(psum_w[i][j]),
                .a_valid_out(act_v[i][j+1]), .a_out(act_d[i][j+1]), .psum_out(psum_w[i+1][j])
            );
        end
    end

    // the bottom row's forwarded valid marks its psum
    always_comb begin
        for (int j = 0; j < `SA_DIM; j++) begin
            col_valid[j] = act_v[`SA_DIM-1][j+1];
            col_psum[j]  = psum_w[`SA_DIM][j];
        end
    end

    result_drain i_drain (
        .s_clk, .s_rst, .col_valid, .col_psum, .out_valid, .out_vec, .done
    );

endmodule

// File: verification/sa_clk_gen.sv
// clock and reset source for the systolic engine testbench, 4 ns period and 2-cycle reset
`timescale 1ns/1ps

module sa_clk_gen (
    output logic s_clk,
    output logic s_rst
);

    initial begin
        s_clk = 1'b0;
        forever #2 s_clk = ~s_clk;
    end

    // release a little after the edge
    initial begin
        s_rst = 1'b1;
        repeat (2) @(posedge s_clk);
        #1;
        s_rst = 1'b0;
    end

endmodule

// File: verification/systolic_props.sv
// credit protocol assertions bound onto the engine top level in the simulation build
`timescale 1ns/1ps
`include "systolic_macros.svh"

module systolic_props import systolic_pkg::*; (
    input logic        s_clk,
    input logic        s_rst,
    input logic        in_valid,
    input logic        in_credit,
    input logic        out_valid,
    input result_vec_t out_vec,
    input logic        out_credit
);

    // beats pushed whose credit is not back yet
    int in_outstanding;
    // results sent but not yet credited by the sink
    int out_outstanding;

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            in_outstanding  <= 0;
            out_outstanding <= 0;
        end else begin
            in_outstanding  <= in_outstanding + int'(in_valid) - int'(in_credit);
            out_outstanding <= out_outstanding + int'(out_valid) - int'(out_credit);
        end
    end

    // a credit returned for a beat never received drives the count below zero
    a_in_credits: assert property (@(posedge s_clk) disable iff (s_rst)
        in_outstanding >= 0 && in_outstanding <= `SA_IN_CREDITS)
        else $error("input beats outstanding out of balance with the queue depth");

    a_out_credits: assert property (@(posedge s_clk) disable iff (s_rst)
        out_outstanding <= `SA_OUT_CREDITS)
        else $error("more results outstanding than output credits");

    a_out_known: assert property (@(posedge s_clk) disable iff (s_rst)
        out_valid |-> !$isunknown(out_vec))
        else $error("result vector has unknown bits while valid");

endmodule

bind systolic_top systolic_props i_props (
    .s_clk(s_clk), .s_rst(s_rst), .in_valid(in_valid), .in_credit(in_credit),
    .out_valid(out_valid), .out_vec(out_vec), .out_credit(out_credit)
);

// File: verification/systolic_tb.sv
// directed testbench for the systolic engine that sends credit-paced beats and checks each result
`timescale 1ns/1ps
`include "systolic_macros.svh"

module systolic_tb import systolic_pkg::*; ();

    localparam int TIMEOUT = 500;

    logic        s_clk;
    logic        s_rst;
    logic        in_valid;
    slice_beat_t in_beat;
    logic        in_credit;
    logic        out_valid;
    result_vec_t out_vec;
    logic        out_credit;

    // golden copy of the stationary weights
    data_t       w_model [`SA_DIM][`SA_DIM];
    slice_beat_t tx_q [$];
    result_vec_t exp_q [$];
    int          credits;
    int          pending;
    int          rx_count;
    bit          hold_credits;
    int          n_checks;
    int          n_errors;
    int          n_tests;
    int          err_base;
    string       cur_test;

    sa_clk_gen i_clk_gen (.s_clk, .s_rst);

    systolic_top i_dut (
        .s_clk, .s_rst, .in_valid, .in_beat, .in_credit, .out_valid, .out_vec, .out_credit
    );

    task automatic check_vec(input result_vec_t exp, input result_vec_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERR %s: expected %h actual %h", cur_test, exp, act);
        end
    endtask

    task automatic check_credits(input int exp, input int act);
        n_checks++;
        if (act != exp) begin
            n_errors++;
            $display("ERR %s: expected %0d actual %0d", cur_test, exp, act);
        end
    endtask

    // c[j] is the sum over i of a[i] * w[i][j], wrapping at 32 bits
    function automatic result_vec_t expected_product(input act_vec_t a);
        result_vec_t c;
        for (int j = 0; j < `SA_DIM; j++) begin
            c[j] = '0;
            for (int i = 0; i < `SA_DIM; i++) begin
                c[j] = c[j] + psum_t'(a[i]) * psum_t'(w_model[i][j]);
            end
        end
        return c;
    endfunction

    function automatic act_vec_t random_vector();
        act_vec_t v;
        for (int i = 0; i < `SA_DIM; i++) begin
            v[i] = data_t'($urandom);
        end
        return v;
    endfunction

    task automatic load_weight(input int r, input int c, input data_t value);
        slice_beat_t b;
        b.kind              = BEAT_WGT;
        b.payload.wgt.row   = `SA_IDX_W'(r);
        b.payload.wgt.col   = `SA_IDX_W'(c);
        b.payload.wgt.value = value;
        tx_q.push_back(b);
        w_model[r][c] = value;
    endtask

    task automatic send_vector(input act_vec_t a);
        slice_beat_t b;
        for (int i = 0; i < `SA_DIM; i++) begin
            b.kind              = BEAT_ACT;
            b.payload.act.rsvd  = '0;
            b.payload.act.lane  = `SA_IDX_W'(i);
            b.payload.act.value = a[i];
            tx_q.push_back(b);
        end
        exp_q.push_back(expected_product(a));
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge s_clk);
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (s_rst !== 1'b0 && n < TIMEOUT) begin
            @(negedge s_clk);
            n++;
        end
        if (s_rst !== 1'b0) begin
            n_errors++;
            $display("reset was never released");
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while ((tx_q.size() != 0 || exp_q.size() != 0 || pending != 0) && n < TIMEOUT) begin
            @(negedge s_clk);
            n++;
        end
        if (tx_q.size() != 0 || exp_q.size() != 0 || pending != 0) begin
            n_errors++;
            $display("%s: timed out with %0d results still missing", cur_test, exp_q.size());
        end
    endtask

    task automatic wait_results(input int target);
        int n;
        n = 0;
        while (rx_count < target && n < TIMEOUT) begin
            @(negedge s_clk);
            n++;
        end
        if (rx_count < target) begin
            n_errors++;
            $display("%s: timed out waiting for results to arrive", cur_test);
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        err_base = n_errors;
        n_tests++;
    endtask

    task automatic finish_test();
        $display("test %s finished, %0d errors", cur_test, n_errors - err_base);
    endtask

    task automatic test_identity();
        start_test("identity");
        for (int i = 0; i < `SA_DIM; i++) begin
            for (int j = 0; j < `SA_DIM; j++) begin
                load_weight(i, j, (i == j) ? data_t'(1) : data_t'(0));
            end
        end
        for (int k = 0; k < 3; k++) begin
            send_vector(random_vector());
        end
        wait_drained();
        finish_test();
    endtask

    task automatic test_random_matrix();
        act_vec_t v;
        start_test("random_matrix");
        // most negative last column, so one vector wraps the sum
        for (int i = 0; i < `SA_DIM; i++) begin
            for (int j = 0; j < `SA_DIM; j++) begin
                load_weight(i, j, (j == `SA_DIM - 1) ? data_t'(16'h8000) : data_t'($urandom));
            end
        end
        for (int k = 0; k < 8; k++) begin
            v = random_vector();
            if (k == 3) begin
                for (int i = 0; i < `SA_DIM; i++) begin
                    v[i] = data_t'(16'h8000);
                end
            end
            send_vector(v);
        end
        wait_drained();
        finish_test();
    endtask

    task automatic test_weight_reload();
        act_vec_t v;
        start_test("weight_reload");
        for (int k = 0; k < 4; k++) begin
            // lane 1 nonzero so the changed weight shows
            v = random_vector();
            v[1] = data_t'(77);
            if (k == 2) begin
                load_weight(1, 2, w_model[1][2] ^ data_t'(16'h5a5a));
            end
            send_vector(v);
        end
        wait_drained();
        finish_test();
    endtask

    task automatic test_output_backpressure();
        int base;
        start_test("output_backpressure");
        base = rx_count;
        hold_credits = 1'b1;
        for (int k = 0; k < 6; k++) begin
            send_vector(random_vector());
        end
        wait_results(base + `SA_OUT_CREDITS);
        idle_cycles(40);
        check_credits(`SA_OUT_CREDITS, rx_count - base);
        hold_credits = 1'b0;
        wait_drained();
        check_credits(6, rx_count - base);
        finish_test();
    endtask

    task automatic test_input_credit_return();
        start_test("input_credit_return");
        send_vector(random_vector());
        wait_drained();
        idle_cycles(10);
        check_credits(`SA_IN_CREDITS, credits);
        finish_test();
    endtask

    // sender and sink sample on the edge and drive 1 ns later
    initial begin
        in_valid     = 1'b0;
        in_beat      = '0;
        out_credit   = 1'b0;
        credits      = `SA_IN_CREDITS;
        pending      = 0;
        rx_count     = 0;
        hold_credits = 1'b0;
        forever begin
            @(posedge s_clk);
            if (in_credit) begin
                credits++;
            end
            if (out_valid) begin
                rx_count++;
                pending++;
                if (exp_q.size() == 0) begin
                    n_errors++;
                    $display("%s: a result arrived that no vector asked for", cur_test);
                end else begin
                    check_vec(exp_q.pop_front(), out_vec);
                end
            end
            #1;
            in_valid   = 1'b0;
            out_credit = 1'b0;
            if (!s_rst && credits > 0 && tx_q.size() > 0) begin
                in_valid = 1'b1;
                in_beat  = tx_q.pop_front();
                credits--;
            end
            if (!hold_credits && pending > 0) begin
                out_credit = 1'b1;
                pending--;
            end
        end
    end

    initial begin
        n_checks = 0;
        n_errors = 0;
        n_tests  = 0;
        void'($urandom(32'h5933));
        wait_reset();
        test_identity();
        test_random_matrix();
        test_weight_reload();
        test_output_backpressure();
        test_input_credit_return();
        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+hdl
hdl/systolic_pkg.sv
hdl/beat_queue.sv
hdl/systolic_pe.sv
hdl/act_skew_stage.sv
hdl/systolic_ctrl.sv
hdl/result_drain.sv
hdl/systolic_top.sv
verification/sa_clk_gen.sv
verification/systolic_props.sv
verification/systolic_tb.sv

// File: run_sim.sh
#!/bin/bash
# builds the systolic engine testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module systolic_tb -o systolic_sim

sim_out=$(./obj_dir/systolic_sim)
echo "$sim_out"
echo "$sim_out" | grep -q "PASS: all tests"
